//--- hdl/afu_mem_pkg.sv
/* Host memory formats */
package afu_mem_pkg;

	// ==============================
	// Line and address widths
	// ==============================
	localparam int line_w = 512;
	localparam int addr_w = 58;

	typedef logic [line_w-1:0] line_t;
	typedef logic [addr_w-1:0] mem_addr_t;

	// Source pointer to first batch line, hand line is the one below
	localparam mem_addr_t input_offset = 58'd50331648 + 58'd16384;

	// Status word of the done write, top 32 bits of the hand line
	localparam logic [31:0] done_code = 32'd16;

	// ==============================
	// Polled line views
	// ==============================
	typedef union packed {
		line_t raw;
		struct packed {
			// Status word, bits 511-480
			logic [28:0]  status_hi;
			logic         tag_1;
			logic         status_mid;
			logic         tag_0;
			logic [22:0]  spare;
			// Reads in this batch, bits 456-448
			logic [8:0]   batch_size;
			logic [447:0] payload;
		} hand;
	} cache_line_u;

endpackage

//--- hdl/afu_batch_pkg.sv
/* Batch and kernel sizes */
package afu_batch_pkg;

	localparam int max_reads = 256;
	localparam int lines_per_read = 4;
	localparam int buf_lines = max_reads * lines_per_read;
	localparam int buf_addr_w = $clog2(buf_lines);

	// One bit wider than the read count, so 256 fits
	typedef logic [8:0] batch_size_t;
	// Lines in a full batch
	typedef logic [10:0] line_count_t;

	localparam int fifo_depth = 16;
	localparam int fifo_addr_w = $clog2(fifo_depth);

	// Kernel words
	typedef logic [31:0] kernel_pos_t;
	// k in the upper half, l in the lower half
	typedef logic [63:0] lookup_req_t;
	// Second line in the upper half
	typedef logic [1023:0] lookup_rsp_t;

endpackage

//--- hdl/sync_fifo.sv
/* Single-clock FIFO */
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width = 64
) (
	input  logic             CLK_400M,
	input  logic             reset_n,
	input  logic             clear,
	input  logic             push,
	input  logic [width-1:0] wdata,
	output logic             full,
	input  logic             pop,
	output logic [width-1:0] rdata,
	output logic             rvalid,
	output logic             empty
);
	logic [width-1:0] mem [afu_batch_pkg::fifo_depth];
	logic [afu_batch_pkg::fifo_addr_w-1:0] wr_ptr;
	logic [afu_batch_pkg::fifo_addr_w-1:0] rd_ptr;
	logic [afu_batch_pkg::fifo_addr_w:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	// Power-of-two depth, top count bit set only when full
	assign full = count[afu_batch_pkg::fifo_addr_w];
	assign empty = (count == '0);

	always_ff @(posedge CLK_400M) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rvalid <= 1'b0;
		end else begin
			rvalid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge CLK_400M) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
		if (do_pop)
			rdata <= mem[rd_ptr];
	end

endmodule

//--- hdl/response_pairer.sv
/* Lookup response pairing */
`timescale 1ns/10ps

module response_pairer (
	input  logic                       CLK_400M,
	input  logic                       reset_n,
	input  logic                       active,
	input  logic                       rx_valid,
	input  afu_mem_pkg::line_t         rx_data,
	output logic                       pair_valid,
	output afu_batch_pkg::lookup_rsp_t pair_data
);
	// High while the k line is held and the l line is awaited
	logic have_first;
	afu_mem_pkg::line_t first_line;

	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			have_first <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= 1'b0;
			if (!active) begin
				have_first <= 1'b0;
			end else if (rx_valid) begin
				// Second line closes the pair
				pair_valid <= have_first;
				have_first <= ~have_first;
			end
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (rx_valid && !have_first)
			first_line <= rx_data;
		if (rx_valid && have_first)
			pair_data <= {rx_data, first_line};
	end

endmodule

//--- hdl/batch_controller.sv
/* Batch controller */
`timescale 1ns/10ps

module batch_controller (
	input  logic                       CLK_400M,
	input  logic                       reset_n,
	input  logic                       core_start,
	input  afu_mem_pkg::mem_addr_t     src_ptr,
	input  afu_mem_pkg::mem_addr_t     dst_ptr,
	input  logic                       rd_almostfull,
	input  logic                       wr_almostfull,
	input  logic                       rx_valid,
	input  afu_mem_pkg::cache_line_u   rx_data,
	output logic                       rd_valid,
	output afu_mem_pkg::mem_addr_t     rd_addr,
	output logic                       wr_valid,
	output logic                       fence_valid,
	output afu_mem_pkg::mem_addr_t     wr_addr,
	output afu_mem_pkg::cache_line_u   wr_data,
	output logic                       kernel_reset_n,
	output logic                       load_valid,
	output afu_mem_pkg::line_t         load_data,
	output logic                       req_pop,
	input  logic                       req_rvalid,
	input  logic                       req_empty,
	input  logic                       req_full,
	input  afu_batch_pkg::lookup_req_t req_data,
	output logic                       out_pop,
	input  logic                       out_rvalid,
	input  logic                       out_empty,
	input  logic                       out_full,
	input  afu_mem_pkg::line_t         out_data,
	output logic                       lookup_active,
	output logic                       fifo_clear,
	output logic                       output_permit,
	output logic                       kernel_stall,
	input  logic                       output_request,
	input  logic                       output_finish
);
	enum logic [2:0] {
		s_idle, s_poll, s_check, s_load, s_feed, s_lookup, s_output, s_close
	} state;

	afu_mem_pkg::mem_addr_t hand_ptr;
	afu_mem_pkg::mem_addr_t input_base;
	afu_mem_pkg::mem_addr_t out_cnt;
	afu_batch_pkg::batch_size_t batch_size;
	afu_batch_pkg::line_count_t line_num;
	afu_batch_pkg::line_count_t load_cnt, fill_cnt, feed_cnt;
	afu_batch_pkg::kernel_pos_t k_pos;
	afu_batch_pkg::kernel_pos_t l_pos;
	logic polling_tag;
	logic tag_ok;
	logic feed_phase;
	logic feed_fire;
	logic l_pending;
	logic out_hold;
	logic [1:0] close_step;
	afu_mem_pkg::line_t batch_buf [afu_batch_pkg::buf_lines];

	assign hand_ptr = src_ptr + afu_mem_pkg::input_offset - 1'b1;
	assign input_base = src_ptr + afu_mem_pkg::input_offset;
	assign line_num = afu_batch_pkg::line_count_t'(batch_size)
		* afu_batch_pkg::line_count_t'(afu_batch_pkg::lines_per_read);
	// Expected tag bit flips with every accepted batch
	assign tag_ok = polling_tag ? rx_data.hand.tag_1 : rx_data.hand.tag_0;
	assign k_pos = req_data[63:32];
	assign feed_fire = (state == s_feed) && !feed_phase && (feed_cnt != line_num);
	// One lookup pair in flight, k read then l read
	assign req_pop = (state == s_lookup) && !output_request && !req_empty
		&& !rd_almostfull && !req_rvalid && !l_pending;
	assign out_pop = (state == s_output) && !out_empty && !out_rvalid && !out_hold;
	assign lookup_active = (state == s_lookup);
	assign fifo_clear = ~kernel_reset_n;
	assign kernel_stall = rd_almostfull | wr_almostfull | req_full | out_full;

	// ==============================
	// Batch buffer
	// ==============================
	always_ff @(posedge CLK_400M) begin
		if (state == s_load && rx_valid)
			batch_buf[fill_cnt[afu_batch_pkg::buf_addr_w-1:0]] <= rx_data.raw;
		if (feed_fire)
			load_data <= batch_buf[feed_cnt[afu_batch_pkg::buf_addr_w-1:0]];
	end

	// ==============================
	// Batch FSM
	// ==============================
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state <= s_idle;
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			fence_valid <= 1'b0;
			load_valid <= 1'b0;
			kernel_reset_n <= 1'b0;
			output_permit <= 1'b0;
			polling_tag <= 1'b0;
			l_pending <= 1'b0;
			out_hold <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			fence_valid <= 1'b0;
			load_valid <= 1'b0;
			case (state)
				s_idle: begin
					if (core_start) begin
						kernel_reset_n <= 1'b0;
						output_permit <= 1'b0;
						state <= s_poll;
					end
				end
				s_poll: begin
					if (!rd_almostfull) begin
						rd_valid <= 1'b1;
						rd_addr <= hand_ptr;
						state <= s_check;
					end
				end
				s_check: begin
					if (rx_valid && tag_ok) begin
						batch_size <= rx_data.hand.batch_size;
						polling_tag <= ~polling_tag;
						load_cnt <= '0;
						fill_cnt <= '0;
						kernel_reset_n <= 1'b1;
						state <= s_load;
					end else if (rx_valid) begin
						state <= s_poll;
					end
				end
				s_load: begin
					if (load_cnt != line_num && !rd_almostfull) begin
						rd_valid <= 1'b1;
						rd_addr <= input_base + afu_mem_pkg::mem_addr_t'(load_cnt);
						load_cnt <= load_cnt + 1'b1;
					end
					if (rx_valid)
						fill_cnt <= fill_cnt + 1'b1;
					if (load_cnt == line_num && fill_cnt == line_num) begin
						feed_cnt <= '0;
						feed_phase <= 1'b0;
						state <= s_feed;
					end
				end
				s_feed: begin
					// A line every second cycle
					feed_phase <= ~feed_phase;
					if (feed_fire) begin
						load_valid <= 1'b1;
						feed_cnt <= feed_cnt + 1'b1;
					end
					if (feed_cnt == line_num) begin
						l_pending <= 1'b0;
						state <= s_lookup;
					end
				end
				s_lookup: begin
					if (req_rvalid) begin
						rd_valid <= 1'b1;
						rd_addr <= src_ptr + afu_mem_pkg::mem_addr_t'(k_pos[31:4]);
						l_pos <= req_data[31:0];
						l_pending <= 1'b1;
					end else if (l_pending) begin
						// Goes out even under read almost-full
						rd_valid <= 1'b1;
						rd_addr <= src_ptr + afu_mem_pkg::mem_addr_t'(l_pos[31:4]);
						l_pending <= 1'b0;
					end else if (output_request) begin
						output_permit <= 1'b1;
						out_cnt <= '0;
						out_hold <= 1'b0;
						state <= s_output;
					end
				end
				s_output: begin
					// Popped line waits in the write registers
					if (out_rvalid) begin
						wr_addr <= dst_ptr + out_cnt;
						wr_data.raw <= out_data;
						out_hold <= 1'b1;
					end
					if (out_hold && !wr_almostfull) begin
						wr_valid <= 1'b1;
						out_cnt <= out_cnt + 1'b1;
						out_hold <= 1'b0;
					end
					if (output_finish && out_empty && !out_rvalid && !out_hold) begin
						output_permit <= 1'b0;
						close_step <= '0;
						state <= s_close;
					end
				end
				s_close: begin
					// Fence, done write, fence
					if (!wr_almostfull) begin
						wr_valid <= 1'b1;
						wr_addr <= hand_ptr;
						close_step <= close_step + 1'b1;
						if (close_step == 2'd1)
							wr_data.raw <= {afu_mem_pkg::done_code,
								{(afu_mem_pkg::line_w - 32){1'b0}}};
						else
							fence_valid <= 1'b1;
						if (close_step == 2'd2)
							state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

//--- hdl/afu_core.sv
/* Accelerator core top */
`timescale 1ns/10ps

module afu_core (
	input  logic                       CLK_400M,
	input  logic                       reset_n,
	input  logic                       core_start,
	input  afu_mem_pkg::mem_addr_t     src_ptr,
	input  afu_mem_pkg::mem_addr_t     dst_ptr,
	// Host read path
	input  logic                       rd_almostfull,
	output logic                       rd_valid,
	output afu_mem_pkg::mem_addr_t     rd_addr,
	input  logic                       rx_valid,
	input  afu_mem_pkg::cache_line_u   rx_data,
	// Host write path
	input  logic                       wr_almostfull,
	output logic                       wr_valid,
	output logic                       fence_valid,
	output afu_mem_pkg::mem_addr_t     wr_addr,
	output afu_mem_pkg::cache_line_u   wr_data,
	// Kernel side
	output logic                       kernel_reset_n,
	output logic                       load_valid,
	output afu_mem_pkg::line_t         load_data,
	input  logic                       req_valid,
	input  afu_batch_pkg::lookup_req_t req_data,
	output logic                       rsp_valid,
	output afu_batch_pkg::lookup_rsp_t rsp_data,
	input  logic                       output_request,
	output logic                       output_permit,
	input  logic                       out_valid,
	input  afu_mem_pkg::line_t         out_data,
	input  logic                       output_finish,
	output logic                       kernel_stall
);
	logic req_pop, req_rvalid, req_empty, req_full;
	logic out_pop, out_rvalid, out_empty, out_full;
	logic lookup_active;
	logic fifo_clear;
	logic pair_valid;
	logic rsp_empty;
	afu_batch_pkg::lookup_req_t req_q;
	afu_batch_pkg::lookup_rsp_t pair_data;
	afu_mem_pkg::line_t out_q;

	// ==============================
	// Control and host access
	// ==============================
	batch_controller u_ctrl (
		.*,
		.req_data(req_q),
		.out_data(out_q)
	);

	response_pairer u_pairer (
		.CLK_400M, .reset_n,
		.active(lookup_active),
		.rx_valid, .rx_data(rx_data.raw),
		.pair_valid, .pair_data
	);

	// ==============================
	// Kernel FIFOs
	// ==============================
	sync_fifo #(.width($bits(afu_batch_pkg::lookup_req_t))) req_fifo (
		.CLK_400M, .reset_n, .clear(fifo_clear),
		.push(req_valid), .wdata(req_data), .full(req_full),
		.pop(req_pop), .rdata(req_q), .rvalid(req_rvalid), .empty(req_empty)
	);

	// Kernel cannot stall responses, drained as soon as present
	sync_fifo #(.width($bits(afu_batch_pkg::lookup_rsp_t))) rsp_fifo (
		.CLK_400M, .reset_n, .clear(fifo_clear),
		.push(pair_valid), .wdata(pair_data), .full(),
		.pop(~rsp_empty), .rdata(rsp_data), .rvalid(rsp_valid), .empty(rsp_empty)
	);

	sync_fifo #(.width(afu_mem_pkg::line_w)) out_fifo (
		.CLK_400M, .reset_n, .clear(fifo_clear),
		.push(out_valid), .wdata(out_data), .full(out_full),
		.pop(out_pop), .rdata(out_q), .rvalid(out_rvalid), .empty(out_empty)
	);

endmodule

//--- testbench/afu_core_properties.sv
/* Host request port assertions */
`timescale 1ns/10ps

module afu_core_properties (
	input logic CLK_400M,
	input logic reset_n,
	input logic rd_valid,
	input logic wr_valid,
	input logic fence_valid,
	input logic wr_almostfull
);
	// No read may start while reset holds
	rd_quiet_in_reset: assert property (@(posedge CLK_400M) !reset_n |-> !$rose(rd_valid))
		else $error("rd_valid rose during reset");

	fence_is_write: assert property (@(posedge CLK_400M) fence_valid |-> wr_valid)
		else $error("fence_valid without wr_valid");

	// Write issue sees the almost-full of the edge before
	write_throttle: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		wr_valid |-> !$past(wr_almostfull))
		else $error("wr_valid after wr_almostfull was high");

endmodule

bind afu_core afu_core_properties props (
	.CLK_400M(CLK_400M),
	.reset_n(reset_n),
	.rd_valid(rd_valid),
	.wr_valid(wr_valid),
	.fence_valid(fence_valid),
	.wr_almostfull(wr_almostfull)
);

//--- testbench/afu_core_tb.sv
/* Accelerator core testbench */
`timescale 1ns/10ps

module afu_core_tb;

	localparam int num_batches = 4;
	localparam afu_mem_pkg::mem_addr_t src_base = 58'h1000;
	localparam afu_mem_pkg::mem_addr_t dst_base = 58'h40_0000;
	// First batch line, hand line sits one below it
	localparam afu_mem_pkg::mem_addr_t first_line = src_base + afu_mem_pkg::input_offset;
	localparam afu_mem_pkg::mem_addr_t hand_addr = first_line - 58'd1;

	logic CLK_400M;
	logic reset_n;
	logic core_start;
	afu_mem_pkg::mem_addr_t src_ptr = src_base;
	afu_mem_pkg::mem_addr_t dst_ptr = dst_base;
	logic rd_almostfull = 1'b0;
	logic wr_almostfull = 1'b0;
	logic rx_valid = 1'b0;
	afu_mem_pkg::cache_line_u rx_data = '0;
	logic req_valid, output_request, out_valid, output_finish;
	afu_batch_pkg::lookup_req_t req_data;
	afu_mem_pkg::line_t out_data;
	logic rd_valid, wr_valid, fence_valid, kernel_reset_n, load_valid;
	logic rsp_valid, output_permit, kernel_stall;
	afu_mem_pkg::mem_addr_t rd_addr, wr_addr;
	afu_mem_pkg::cache_line_u wr_data;
	afu_mem_pkg::line_t load_data;
	afu_batch_pkg::lookup_rsp_t rsp_data;

	// Host memory and expected traffic
	logic [31:0] lfsr = 32'hae9a;
	afu_mem_pkg::line_t host_mem [afu_mem_pkg::mem_addr_t];
	afu_mem_pkg::mem_addr_t pend [$];
	afu_mem_pkg::mem_addr_t exp_rd [$];
	afu_mem_pkg::mem_addr_t exp_wr_addr [$];
	afu_mem_pkg::cache_line_u exp_wr_line [$];
	logic exp_wr_fence [$];
	afu_batch_pkg::lookup_rsp_t exp_pair [$];
	int rsp_wait = 0;
	int polls_left = 0;
	afu_batch_pkg::batch_size_t cur_size = '0;
	logic cur_tag = 1'b0;
	int load_seen = 0;
	int load_base = 0;
	int rsp_seen = 0;
	int wr_seen = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	afu_core dut (.*);

	initial begin
		CLK_400M = 1'b0;
		forever #2 CLK_400M = ~CLK_400M;
	end

	// ==============================
	// Random source
	// ==============================
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
			r = (r << 1) | int'(lfsr_bit());
		return r;
	endfunction

	function automatic afu_mem_pkg::line_t rand_line();
		afu_mem_pkg::line_t r;
		for (int i = 0; i < afu_mem_pkg::line_w; i++)
			r[i] = lfsr_bit();
		return r;
	endfunction

	// Lines appear on first touch and stay fixed
	function automatic afu_mem_pkg::line_t line_at(input afu_mem_pkg::mem_addr_t a);
		if (!host_mem.exists(a))
			host_mem[a] = rand_line();
		return host_mem[a];
	endfunction

	// Rejected polls carry only the other tag bit
	function automatic afu_mem_pkg::cache_line_u hand_line(input logic accept);
		afu_mem_pkg::cache_line_u h;
		h.raw = '0;
		h.hand.batch_size = cur_size;
		if (cur_tag) begin
			h.hand.tag_1 = accept;
			h.hand.tag_0 = ~accept;
		end else begin
			h.hand.tag_0 = accept;
			h.hand.tag_1 = ~accept;
		end
		return h;
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_flag(input logic got, input logic want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_addr(input afu_mem_pkg::mem_addr_t got,
		input afu_mem_pkg::mem_addr_t want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_line(input afu_mem_pkg::cache_line_u got,
		input afu_mem_pkg::cache_line_u want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
				$time, what, got.raw, want.raw);
		end
	endtask

	task automatic check_pair(input afu_batch_pkg::lookup_rsp_t got,
		input afu_batch_pkg::lookup_rsp_t want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, want);
		end
	endtask

	// ==============================
	// Host model
	// ==============================
	always @(posedge CLK_400M) begin
		rd_almostfull <= (rand_bits(2) == 0);
		wr_almostfull <= (rand_bits(2) == 0);
	end

	always @(posedge CLK_400M) begin : host_model
		afu_mem_pkg::mem_addr_t a;
		afu_mem_pkg::cache_line_u el;
		logic ef;
		rx_valid <= 1'b0;
		if (reset_n && rd_valid) begin
			pend.push_back(rd_addr);
			if (exp_rd.size() == 0) begin
				errors++;
				$display("Unexpected host read to %h at %0t ns", rd_addr, $time);
			end else begin
				check_addr(rd_addr, exp_rd.pop_front(), "host read address");
			end
		end
		// In-order responses after a random gap
		if (rsp_wait > 0) begin
			rsp_wait--;
		end else if (pend.size() > 0) begin
			a = pend.pop_front();
			if (a == hand_addr) begin
				rx_data <= hand_line(polls_left == 0);
				if (polls_left > 0)
					polls_left--;
			end else begin
				rx_data.raw <= line_at(a);
			end
			rx_valid <= 1'b1;
			rsp_wait = rand_bits(2);
		end
		if (reset_n && wr_valid) begin
			wr_seen++;
			if (exp_wr_fence.size() == 0) begin
				errors++;
				$display("Unexpected host write to %h at %0t ns", wr_addr, $time);
			end else begin
				a = exp_wr_addr.pop_front();
				el = exp_wr_line.pop_front();
				ef = exp_wr_fence.pop_front();
				check_flag(fence_valid, ef, "fence flag");
				if (!ef) begin
					check_addr(wr_addr, a, "host write address");
					check_line(wr_data, el, "host write data");
				end
			end
		end
	end

	// ==============================
	// Kernel side monitor
	// ==============================
	always @(posedge CLK_400M) begin
		// At most eight entries per batch, so neither kernel FIFO fills
		if (reset_n)
			check_flag(kernel_stall, rd_almostfull | wr_almostfull, "kernel stall");
		if (reset_n && load_valid) begin
			check_line(load_data,
				line_at(first_line + afu_mem_pkg::mem_addr_t'(load_seen - load_base)),
				"load line");
			load_seen++;
		end
		if (reset_n && rsp_valid) begin
			rsp_seen++;
			if (exp_pair.size() == 0) begin
				errors++;
				$display("Unexpected lookup response record at %0t ns", $time);
			end else begin
				check_pair(rsp_data, exp_pair.pop_front(), "lookup response pair");
			end
		end
	end

	task automatic expect_write(input afu_mem_pkg::mem_addr_t a, input afu_mem_pkg::line_t d,
		input logic fence);
		afu_mem_pkg::cache_line_u wl;
		wl.raw = d;
		exp_wr_addr.push_back(a);
		exp_wr_line.push_back(wl);
		exp_wr_fence.push_back(fence);
	endtask

	// One batch from core_start to the closing fence
	task automatic run_batch(input int b);
		int rejects, nlines, nreq, nout, n, base, err0;
		afu_batch_pkg::kernel_pos_t k, l;
		afu_mem_pkg::mem_addr_t ka, la;
		afu_mem_pkg::line_t line;
		err0 = errors;
		cur_size = afu_batch_pkg::batch_size_t'(1 + rand_bits(3));
		cur_tag = b[0];
		rejects = rand_bits(1);
		polls_left = rejects;
		nlines = int'(cur_size) * afu_batch_pkg::lines_per_read;
		nreq = 1 + rand_bits(3);
		nout = 1 + rand_bits(3);
		for (int i = 0; i <= rejects; i++)
			exp_rd.push_back(hand_addr);
		for (int i = 0; i < nlines; i++)
			exp_rd.push_back(first_line + afu_mem_pkg::mem_addr_t'(i));
		load_base = load_seen;
		@(posedge CLK_400M);
		core_start <= 1'b1;
		@(posedge CLK_400M);
		core_start <= 1'b0;
		while (load_seen - load_base < nlines)
			@(posedge CLK_400M);

		// Lookups, positions kept below the input region
		base = rsp_seen;
		n = 0;
		while (n < nreq) begin
			@(posedge CLK_400M);
			req_valid <= 1'b0;
			if (!kernel_stall) begin
				k = afu_batch_pkg::kernel_pos_t'(rand_bits(24));
				l = afu_batch_pkg::kernel_pos_t'(rand_bits(24));
				ka = src_base + afu_mem_pkg::mem_addr_t'(k[31:4]);
				la = src_base + afu_mem_pkg::mem_addr_t'(l[31:4]);
				req_valid <= 1'b1;
				req_data <= {k, l};
				exp_rd.push_back(ka);
				exp_rd.push_back(la);
				exp_pair.push_back({line_at(la), line_at(ka)});
				n++;
			end
		end
		@(posedge CLK_400M);
		req_valid <= 1'b0;
		while (rsp_seen - base < nreq)
			@(posedge CLK_400M);

		// Output lines, then the close sequence
		output_request <= 1'b1;
		@(posedge CLK_400M);
		while (!output_permit)
			@(posedge CLK_400M);
		output_request <= 1'b0;
		base = wr_seen;
		n = 0;
		while (n < nout) begin
			@(posedge CLK_400M);
			out_valid <= 1'b0;
			if (!kernel_stall) begin
				line = rand_line();
				out_valid <= 1'b1;
				out_data <= line;
				expect_write(dst_base + afu_mem_pkg::mem_addr_t'(n), line, 1'b0);
				n++;
			end
		end
		expect_write(hand_addr, '0, 1'b1);
		expect_write(hand_addr, {afu_mem_pkg::done_code, 480'd0}, 1'b0);
		expect_write(hand_addr, '0, 1'b1);
		@(posedge CLK_400M);
		out_valid <= 1'b0;
		output_finish <= 1'b1;
		while (wr_seen - base < nout + 3)
			@(posedge CLK_400M);
		output_finish <= 1'b0;

		if (exp_rd.size() != 0 || exp_pair.size() != 0) begin
			errors++;
			$display("Batch %0d ended with %0d reads and %0d response records missing",
				b, exp_rd.size(), exp_pair.size());
		end
		tests++;
		$display("batch %0d: %0d lines, %0d rejected polls, %0d lookups, %0d outputs, %s",
			b, nlines, rejects, nreq, nout, (errors == err0) ? "ok" : "errors");
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		reset_n = 1'b0;
		core_start = 1'b0;
		req_valid = 1'b0;
		req_data = '0;
		output_request = 1'b0;
		out_valid = 1'b0;
		out_data = '0;
		output_finish = 1'b0;
		repeat (8) @(posedge CLK_400M);
		check_flag(rd_valid, 1'b0, "rd_valid in reset");
		check_flag(wr_valid, 1'b0, "wr_valid in reset");
		check_flag(fence_valid, 1'b0, "fence_valid in reset");
		check_flag(load_valid, 1'b0, "load_valid in reset");
		check_flag(rsp_valid, 1'b0, "rsp_valid in reset");
		check_flag(output_permit, 1'b0, "output_permit in reset");
		check_flag(kernel_reset_n, 1'b0, "kernel_reset_n in reset");
		reset_n <= 1'b1;
		tests++;
		$display("reset: %s", (errors == 0) ? "ok" : "errors");
		for (int b = 0; b < num_batches; b++)
			run_batch(b);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		repeat (num_batches * 20000) @(posedge CLK_400M);
		$display("Watchdog expired after %0d cycles, a batch never completed",
			num_batches * 20000);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- src.f
hdl/afu_mem_pkg.sv
hdl/afu_batch_pkg.sv
hdl/sync_fifo.sv
hdl/response_pairer.sv
hdl/batch_controller.sv
hdl/afu_core.sv
testbench/afu_core_properties.sv
testbench/afu_core_tb.sv

//--- Makefile
# Verilator flow for the accelerator core

TOP = afu_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
